// ==== jenc_config.svh ====
`ifndef JENC_CONFIG_SVH
`define JENC_CONFIG_SVH

// ####################
// coefficient path
// ####################

// signed DCT coefficient as it enters the quantizer.
`define JENC_CW 12

// coefficients per 8x8 block, in zigzag order.
`define JENC_BLOCK 64

// ####################
// control and status
// ####################

// compression factor, added to the per-position shift.
`define JENC_QF_BITS 3

// byte count of one frame, wide enough for a full sensor image.
`define JENC_SIZE_BITS 20

`endif

// ==== jenc_pkg.sv ====
`default_nettype none

`include "jenc_config.svh"

package jenc_pkg;

    // one quantized or raw coefficient.
    typedef logic signed [`JENC_CW-1:0] coeff_t;

    // code word at the LSB, symbol first and amplitude bits after it.
    typedef logic [19:0] code_t;

    // number of valid bits in a code word.
    typedef logic [4:0] code_len_t;

    // position inside a block.
    typedef logic [$clog2(`JENC_BLOCK)-1:0] zz_idx_t;

    typedef logic [7:0] byte_t;
    typedef logic [31:0] word_t;

    // valid bytes in an output word, 1 to 4.
    typedef logic [2:0] byte_cnt_t;

    typedef enum logic [1:0] {
        ent_dc,   // next coefficient is the DC of a block.
        ent_ac,
        ent_zrl,  // flushing groups of 16 zeros.
        ent_eob
    } ent_state_t;

endpackage

`default_nettype wire

// ==== quant.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "jenc_config.svh"

module quant (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`JENC_QF_BITS-1:0] compression_factor,
    input  jenc_pkg::coeff_t         di,
    input  logic                     di_valid,
    input  logic                     di_tlast,
    output logic                     di_hold,
    output jenc_pkg::coeff_t         q,
    output logic                     q_valid,
    output logic                     q_tlast,
    input  logic                     q_hold
);
    import jenc_pkg::*;

    zz_idx_t             zz;
    logic [1:0]          base_shift;
    logic [3:0]          shift;
    logic                neg;
    logic [`JENC_CW-1:0] mag;
    logic [`JENC_CW-1:0] mag_q;
    coeff_t              q_next;
    logic                take;

    assign di_hold = q_valid & q_hold;  // full only while the result is stuck.
    assign take    = di_valid & ~di_hold;

    // ####################
    // shift per zigzag position
    // ####################

    // coarser steps for the higher frequencies.
    always_comb begin
        if (zz == '0) begin
            base_shift = 2'd0;
        end else if (zz < zz_idx_t'(16)) begin
            base_shift = 2'd1;
        end else if (zz < zz_idx_t'(40)) begin
            base_shift = 2'd2;
        end else begin
            base_shift = 2'd3;
        end
    end

    assign shift = {2'b00, base_shift} + {1'b0, compression_factor};

    // shifting the magnitude rounds toward zero for both signs.
    assign neg    = di[`JENC_CW-1];
    assign mag    = neg ? -di : di;
    assign mag_q  = mag >> shift;
    assign q_next = neg ? -coeff_t'(mag_q) : coeff_t'(mag_q);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q_valid <= 1'b0;
            zz      <= '0;
        end else begin
            if (take) begin
                q_valid <= 1'b1;
                zz      <= zz + zz_idx_t'(1);  // wraps at the block size.
            end else if (!q_hold) begin
                q_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            q       <= q_next;
            q_tlast <= di_tlast;
        end
    end

endmodule

`default_nettype wire

// ==== entropy.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "jenc_config.svh"

module entropy (
    input  logic                clk,
    input  logic                rst_n,
    input  jenc_pkg::coeff_t    q,
    input  logic                q_valid,
    input  logic                q_tlast,
    output logic                q_hold,
    output jenc_pkg::code_t     code,
    output jenc_pkg::code_len_t code_len,
    output logic                code_valid,
    output logic                code_tlast,
    input  logic                code_hold
);
    import jenc_pkg::*;

    localparam byte_t sym_zrl = 8'hf0;
    localparam byte_t sym_eob = 8'h00;

    ent_state_t               state;
    zz_idx_t                  idx;
    logic [5:0]               run;        // zeros since the last coded AC.
    coeff_t                   pred;
    logic                     eob_tlast;
    logic signed [`JENC_CW:0] dc_diff;
    logic signed [`JENC_CW:0] val;
    logic [3:0]               val_size;
    byte_t                    sym;
    logic                     out_free;
    logic                     take;
    logic                     emit_val;
    logic                     last;
    logic                     is_zero;

    // number of bits in the magnitude.
    function automatic logic [3:0] bit_size(input logic signed [`JENC_CW:0] v);
        logic [`JENC_CW:0] m;
        logic [3:0]        n;
        m = v[`JENC_CW] ? -v : v;
        n = 4'd0;
        for (int i = 0; i <= `JENC_CW; i++) begin
            if (m[i]) n = 4'(i + 1);
        end
        return n;
    endfunction

    // negative values are sent as value minus one, cut to sz bits.
    function automatic code_t amp_code(input byte_t s, input logic signed [`JENC_CW:0] v,
                                       input logic [3:0] sz);
        logic [`JENC_CW:0] amp;
        logic [`JENC_CW:0] mask;
        amp  = v[`JENC_CW] ? v - 1'b1 : v;
        mask = ((`JENC_CW+1)'(1) << sz) - 1'b1;
        return (code_t'(s) << sz) | code_t'(amp & mask);
    endfunction

    assign out_free = ~code_valid | ~code_hold;
    assign is_zero  = (q == '0);
    assign last     = (idx == zz_idx_t'(`JENC_BLOCK-1));
    assign dc_diff  = {q[`JENC_CW-1], q} - {pred[`JENC_CW-1], pred};
    assign val      = (state == ent_dc) ? dc_diff : {q[`JENC_CW-1], q};
    assign val_size = bit_size(val);
    assign sym      = (state == ent_dc) ? {4'h0, val_size} : {run[3:0], val_size};

    // ####################
    // input acceptance
    // ####################

    always_comb begin
        case (state)
            ent_dc:  q_hold = ~out_free;
            ent_ac:  q_hold = ~is_zero & ((run >= 6'd16) | ~out_free);  // zeros are free.
            default: q_hold = 1'b1;
        endcase
    end

    assign take     = q_valid & ~q_hold;
    assign emit_val = take & ((state == ent_dc) | ~is_zero);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ent_dc;
            idx        <= '0;
            run        <= '0;
            pred       <= '0;
            code_valid <= 1'b0;
        end else begin
            if (code_valid && !code_hold) code_valid <= 1'b0;
            if (take) idx <= idx + zz_idx_t'(1);
            if (take && q_tlast) begin
                pred <= '0;  // each frame starts its own DC chain.
            end else if (take && state == ent_dc) begin
                pred <= q;
            end
            case (state)
                ent_dc: begin
                    if (take) begin
                        code_valid <= 1'b1;
                        run        <= '0;
                        state      <= ent_ac;
                    end
                end
                ent_ac: begin
                    if (take && is_zero) begin
                        run <= run + 6'd1;
                        if (last) state <= ent_eob;
                    end else if (take) begin
                        code_valid <= 1'b1;
                        run        <= '0;
                        if (last) state <= ent_dc;
                    end else if (q_valid && !is_zero && run >= 6'd16) begin
                        state <= ent_zrl;
                    end
                end
                ent_zrl: begin
                    if (out_free) begin
                        code_valid <= 1'b1;
                        run        <= run - 6'd16;
                        if (run < 6'd32) state <= ent_ac;
                    end
                end
                default: begin
                    if (out_free) begin
                        code_valid <= 1'b1;
                        run        <= '0;
                        state      <= ent_dc;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take && is_zero) eob_tlast <= q_tlast;
        if (emit_val) begin
            code       <= amp_code(sym, val, val_size);
            code_len   <= code_len_t'(8) + code_len_t'(val_size);
            code_tlast <= q_tlast;
        end else if (state == ent_zrl && out_free) begin
            code       <= code_t'(sym_zrl);
            code_len   <= code_len_t'(8);
            code_tlast <= 1'b0;
        end else if (state == ent_eob && out_free) begin
            code       <= code_t'(sym_eob);
            code_len   <= code_len_t'(8);
            code_tlast <= eob_tlast;
        end
    end

endmodule

`default_nettype wire

// ==== bitpacker.sv ====
`timescale 1ns/1ns
`default_nettype none

module bitpacker (
    input  logic                clk,
    input  logic                rst_n,
    input  jenc_pkg::code_t     code,
    input  jenc_pkg::code_len_t code_len,
    input  logic                code_valid,
    input  logic                code_tlast,
    output logic                code_hold,
    output jenc_pkg::byte_t     b_data,
    output logic                b_valid,
    output logic                b_tlast,
    input  logic                b_hold
);
    import jenc_pkg::*;

    logic [31:0] acc;         // newest bit at the LSB.
    logic [5:0]  nbits;
    logic        flushing;
    logic        stuff_pend;
    logic        stuff_last;
    logic        out_free;
    logic        full;
    logic        emit;
    logic        take;
    logic        last_now;
    logic [5:0]  bits_left;
    byte_t       top_byte;
    byte_t       pad_byte;
    byte_t       emit_byte;

    assign out_free = ~b_valid | ~b_hold;
    assign full     = (nbits >= 6'd8);

    // a new code only goes in once all whole bytes are out.
    assign code_hold = stuff_pend | flushing | full;
    assign take      = code_valid & ~code_hold;

    // ####################
    // byte selection
    // ####################

    assign top_byte  = byte_t'(acc >> (nbits - 6'd8));
    assign pad_byte  = byte_t'(acc << (6'd8 - nbits)) | (8'hff >> nbits);  // fill with ones.
    assign emit_byte = full ? top_byte : pad_byte;
    assign emit      = out_free & ~stuff_pend & (full | (flushing & (nbits != 6'd0)));
    assign bits_left = full ? nbits - 6'd8 : 6'd0;
    assign last_now  = flushing & (bits_left == 6'd0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            nbits      <= '0;
            flushing   <= 1'b0;
            stuff_pend <= 1'b0;
            b_valid    <= 1'b0;
        end else begin
            if (b_valid && !b_hold) b_valid <= 1'b0;
            if (take) begin
                nbits    <= nbits + {1'b0, code_len};
                flushing <= code_tlast;
            end
            if (out_free && stuff_pend) begin
                b_valid    <= 1'b1;
                stuff_pend <= 1'b0;
                if (stuff_last) flushing <= 1'b0;
            end else if (emit) begin
                b_valid <= 1'b1;
                nbits   <= bits_left;
                if (emit_byte == 8'hff) begin
                    stuff_pend <= 1'b1;  // the 0x00 goes out next.
                end else if (last_now) begin
                    flushing <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) acc <= (acc << code_len) | 32'(code);
        if (out_free && stuff_pend) begin
            b_data  <= 8'h00;
            b_tlast <= stuff_last;
        end else if (emit) begin
            b_data     <= emit_byte;
            b_tlast    <= last_now & (emit_byte != 8'hff);
            stuff_last <= last_now;
        end
    end

endmodule

`default_nettype wire

// ==== bytepacker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "jenc_config.svh"

module bytepacker (
    input  logic                       clk,
    input  logic                       rst_n,
    input  jenc_pkg::byte_t            b_data,
    input  logic                       b_valid,
    input  logic                       b_tlast,
    output logic                       b_hold,
    output jenc_pkg::word_t            out_data,
    output jenc_pkg::byte_cnt_t        out_bytes,
    output logic                       out_valid,
    output logic                       out_tlast,
    input  logic                       out_hold,
    output logic [`JENC_SIZE_BITS-1:0] size
);
    import jenc_pkg::*;

    logic [23:0]                 held;       // bytes waiting for a full word.
    logic [1:0]                  cnt;
    logic [`JENC_SIZE_BITS-1:0]  frame_cnt;
    word_t                       word;
    logic                        take;
    logic                        word_done;
    logic                        out_take;

    assign b_hold    = out_valid & out_hold;
    assign take      = b_valid & ~b_hold;
    assign word_done = take & ((cnt == 2'd3) | b_tlast);
    assign out_take  = out_valid & ~out_hold;

    // the first byte of a word lands in the top lane.
    always_comb begin
        case (cnt)
            2'd0:    word = {b_data, 24'h0};
            2'd1:    word = {held[23:16], b_data, 16'h0};
            2'd2:    word = {held[23:8], b_data, 8'h0};
            default: word = {held, b_data};
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt       <= '0;
            out_valid <= 1'b0;
            frame_cnt <= '0;
            size      <= '0;
        end else begin
            if (out_take) out_valid <= 1'b0;
            if (word_done) begin
                out_valid <= 1'b1;
                cnt       <= '0;
            end else if (take) begin
                cnt <= cnt + 2'd1;
            end
            if (out_take && out_tlast) begin
                size      <= frame_cnt + {{(`JENC_SIZE_BITS-3){1'b0}}, out_bytes};
                frame_cnt <= '0;
            end else if (out_take) begin
                frame_cnt <= frame_cnt + {{(`JENC_SIZE_BITS-3){1'b0}}, out_bytes};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (word_done) begin
            out_data  <= word;
            out_bytes <= byte_cnt_t'(cnt) + byte_cnt_t'(1);
            out_tlast <= b_tlast;
        end else if (take) begin
            case (cnt)
                2'd0:    held[23:16] <= b_data;
                2'd1:    held[15:8]  <= b_data;
                default: held[7:0]   <= b_data;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== jenc.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "jenc_config.svh"

module jenc (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`JENC_QF_BITS-1:0]   compression_factor,
    input  jenc_pkg::coeff_t           di,
    input  logic                       di_valid,
    input  logic                       di_tlast,
    output logic                       di_hold,
    output jenc_pkg::word_t            out_data,
    output jenc_pkg::byte_cnt_t        out_bytes,
    output logic                       out_tlast,
    output logic                       out_valid,
    input  logic                       out_hold,
    output logic [`JENC_SIZE_BITS-1:0] size
);
    import jenc_pkg::*;

    // ####################
    // stage links
    // ####################

    coeff_t    q;
    logic      q_valid;
    logic      q_tlast;
    logic      q_hold;

    code_t     code;       // run/size symbol with its amplitude bits.
    code_len_t code_len;
    logic      code_valid;
    logic      code_tlast;
    logic      code_hold;

    byte_t     b_data;     // stuffed byte stream.
    logic      b_valid;
    logic      b_tlast;
    logic      b_hold;

    quant quant (.*);

    entropy entropy (.*);

    bitpacker bitpacker (.*);

    bytepacker bytepacker (.*);

endmodule

`default_nettype wire

// ==== jenc_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module jenc_asserts (
    input logic                clk,
    input logic                rst_n,
    input jenc_pkg::coeff_t    q,
    input logic                q_valid,
    input logic                q_tlast,
    input logic                q_hold,
    input jenc_pkg::code_t     code,
    input jenc_pkg::code_len_t code_len,
    input logic                code_valid,
    input logic                code_tlast,
    input logic                code_hold,
    input jenc_pkg::byte_t     b_data,
    input logic                b_valid,
    input logic                b_tlast,
    input logic                b_hold,
    input jenc_pkg::word_t     out_data,
    input jenc_pkg::byte_cnt_t out_bytes,
    input logic                out_valid,
    input logic                out_tlast,
    input logic                out_hold
);

    int n_errors = 0;  // failures seen so far.

    // ####################
    // valid/hold links
    // ####################

    a_q_stable: assert property (@(posedge clk) disable iff (!rst_n)
        q_valid && q_hold |=> q_valid && $stable(q) && $stable(q_tlast))
        else begin
            n_errors++;
            $error("quant output changed while held");
        end

    a_code_stable: assert property (@(posedge clk) disable iff (!rst_n)
        code_valid && code_hold |=> code_valid && $stable(code) && $stable(code_len)
            && $stable(code_tlast))
        else begin
            n_errors++;
            $error("entropy output changed while held");
        end

    a_b_stable: assert property (@(posedge clk) disable iff (!rst_n)
        b_valid && b_hold |=> b_valid && $stable(b_data) && $stable(b_tlast))
        else begin
            n_errors++;
            $error("bitpacker output changed while held");
        end

    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_hold |=> out_valid && $stable(out_data) && $stable(out_bytes)
            && $stable(out_tlast))
        else begin
            n_errors++;
            $error("output word changed while held");
        end

    // ####################
    // reset and lanes
    // ####################

    a_reset_valid: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else begin
            n_errors++;
            $error("out_valid high right after reset");
        end

    a_out_bytes: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (out_bytes >= 3'd1) && (out_bytes <= 3'd4))
        else begin
            n_errors++;
            $error("out_bytes outside 1 to 4");
        end

endmodule

`default_nettype wire

// ==== jenc_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "jenc_config.svh"

module jenc_tb;
    import jenc_pkg::*;

    localparam int clk_period = 40;
    localparam int frames     = 2;
    localparam int n_coeffs   = 2 * `JENC_BLOCK;
    localparam int timeout_ns = (frames * n_coeffs + 200) * clk_period * 4;

    // ####################
    // test data layout
    // ####################

    localparam int at_cf     = 0;
    localparam int at_coeffs = 1;
    localparam int at_nwords = at_coeffs + n_coeffs;
    localparam int at_words  = at_nwords + 1;  // each word takes two entries and the size follows.

    logic                       clk;
    logic                       rst_n;
    logic [`JENC_QF_BITS-1:0]   compression_factor;
    coeff_t                     di;
    logic                       di_valid;
    logic                       di_tlast;
    logic                       di_hold;
    word_t                      out_data;
    byte_cnt_t                  out_bytes;
    logic                       out_tlast;
    logic                       out_valid;
    logic                       out_hold;
    logic [`JENC_SIZE_BITS-1:0] size;

    logic [31:0] testdata [0:255];
    integer      seed;
    int          n_words;
    word_t       rx_data [$];
    byte_cnt_t   rx_bytes [$];
    logic        rx_last [$];
    word_t       first_run [$];  // words seen without back-pressure.

    jenc i_dut (
        .clk                (clk),
        .rst_n              (rst_n),
        .compression_factor (compression_factor),
        .di                 (di),
        .di_valid           (di_valid),
        .di_tlast           (di_tlast),
        .di_hold            (di_hold),
        .out_data           (out_data),
        .out_bytes          (out_bytes),
        .out_tlast          (out_tlast),
        .out_valid          (out_valid),
        .out_hold           (out_hold),
        .size               (size)
    );

    bind jenc jenc_asserts i_asserts (
        .clk        (clk),
        .rst_n      (rst_n),
        .q          (q),
        .q_valid    (q_valid),
        .q_tlast    (q_tlast),
        .q_hold     (q_hold),
        .code       (code),
        .code_len   (code_len),
        .code_valid (code_valid),
        .code_tlast (code_tlast),
        .code_hold  (code_hold),
        .b_data     (b_data),
        .b_valid    (b_valid),
        .b_tlast    (b_tlast),
        .b_hold     (b_hold),
        .out_data   (out_data),
        .out_bytes  (out_bytes),
        .out_valid  (out_valid),
        .out_tlast  (out_tlast),
        .out_hold   (out_hold)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(timeout_ns);
        $display("ERROR: timeout after %0d ns, the frame never completed.", timeout_ns);
        $display("Simulation finished: FAIL");
        $fatal(1, "timeout");
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("FAILED at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got,
                     expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    // one coefficient per transfer in zigzag order.
    task automatic send_frame();
        int i;
        @(negedge clk);
        for (i = 0; i < n_coeffs; i++) begin
            di       = coeff_t'(testdata[at_coeffs + i][`JENC_CW-1:0]);
            di_tlast = (i == n_coeffs - 1);
            di_valid = 1'b1;
            while (di_hold) @(negedge clk);  // hold only moves on the rising edge.
            @(negedge clk);
        end
        di_valid = 1'b0;
        di_tlast = 1'b0;
    endtask

    task automatic collect_frame(input logic random_hold);
        logic [31:0] rnd;
        logic        done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            rnd      = $random(seed);
            out_hold = random_hold & rnd[0];
            // the word leaves at the next rising edge.
            if (out_valid && !out_hold) begin
                rx_data.push_back(out_data);
                rx_bytes.push_back(out_bytes);
                rx_last.push_back(out_tlast);
                done = out_tlast;
            end
        end
        @(negedge clk);  // size is updated by now.
        out_hold = 1'b0;
    endtask

    task automatic check_frame(input int run);
        int i;
        int sum;
        sum = 0;
        check_value(rx_data.size(), n_words, "word count");
        for (i = 0; i < n_words; i++) begin
            check_value(32'(rx_bytes[i]), testdata[at_words + 2 * i + 1], "out_bytes");
            check_value(32'(rx_last[i]), 32'(i == n_words - 1), "out_tlast");
            if (run == 0) begin
                check_value(rx_data[i], testdata[at_words + 2 * i], "output word");
                first_run.push_back(rx_data[i]);
            end else begin
                check_value(rx_data[i], first_run[i], "word against the first run");
            end
            sum += int'(rx_bytes[i]);
        end
        check_value(32'(size), testdata[at_words + 2 * n_words], "size");
        check_value(32'(size), 32'(sum), "size against the counted bytes");
    endtask

    initial begin
        int run;
        seed               = 32'h514d;
        rst_n              = 1'b0;
        compression_factor = '0;
        di                 = '0;
        di_valid           = 1'b0;
        di_tlast           = 1'b0;
        out_hold           = 1'b0;
        $readmemh("jenc_testdata.txt", testdata);
        compression_factor = testdata[at_cf][`JENC_QF_BITS-1:0];
        n_words            = int'(testdata[at_nwords]);
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // every stage comes out of reset empty.
        check_value(32'(di_hold), 32'd0, "di_hold after reset");
        check_value(32'(out_valid), 32'd0, "out_valid after reset");
        check_value(32'(size), 32'd0, "size after reset");

        // the second run has random back-pressure and no reset before it.
        for (run = 0; run < frames; run++) begin
            rx_data.delete();
            rx_bytes.delete();
            rx_last.delete();
            fork
                send_frame();
                collect_frame(run == 1);
            join
            check_frame(run);
        end

        if (i_dut.i_asserts.n_errors != 0) begin
            $display("ERROR: %0d assertion failures on the stage links.",
                     i_dut.i_asserts.n_errors);
            $display("Simulation finished: FAIL");
            $fatal(1, "assertion failures");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== jenc_testdata.txt ====
// compression factor, 128 coefficients in zigzag order (12-bit two's complement, 8 per line),
// word count, then per word its data and byte count, and last the frame size in bytes.
001
// block 0
065 fea 1fe 003 000 ffd 000 000
000 000 000 000 000 000 000 000
000 000 000 000 ff9 000 000 00d
000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000
fce 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000
// block 1
05f 019 ffa 000 000 000 000 000
000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000
000 000 00f 000 000 000 000 000
000 000 000 000 000 000 000 ff1
// expected output
5
06c80d03 4
ff00f041 4
f8010000 4
401e0100 4
7f000000 1
11

// ==== compile.f ====
+incdir+.
jenc_pkg.sv
quant.sv
entropy.sv
bitpacker.sv
bytepacker.sv
jenc.sv
jenc_asserts.sv
jenc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module jenc_tb -f compile.f -o jenc_sim \
    > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/jenc_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
fi
echo "no pass line in sim.log"
exit 1
